//--- riscv_core.f
logic/riscv_pkg.sv
logic/alu.sv
logic/datapath.sv
logic/control_unit.sv
logic/load_store_unit.sv
logic/riscv_core.sv
testbench/clock_gen.sv
testbench/riscv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the core and its testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f riscv_core.f --top-module riscv_core_tb -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log

//--- testbench/riscv_core_tb.sv
`default_nettype none

module riscv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import riscv_pkg::*;

    localparam int          NUM_ENTRIES = 34;
    localparam logic [31:0] HALT_PC     = 32'h0000_0158;  // Self-jump at word 86
    localparam logic [4:0]  X0          = 5'd0;

    logic                   clk;
    logic                   rst_n;
    logic [31:0]            instr;
    logic [31:0]            dmem_rdata;
    logic [31:0]            pc;
    dmem_req_t              dmem_req;
    logic [31:0]            imem [128];
    logic [31:0]            dmem [64];
    string                  names [NUM_ENTRIES];
    dmem_req_t              exp_req [NUM_ENTRIES];
    logic [31:0]            exp_word [NUM_ENTRIES];
    int                     n_entries;
    int                     n_words;

    clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    riscv_core riscv_core_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .dmem_rdata (dmem_rdata),
        .pc         (pc),
        .dmem_req   (dmem_req)
    );

    assign instr      = imem[pc[8:2]];             // Asynchronous fetch
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];  // Asynchronous word read

    always @(posedge clk) begin
        if (rst_n && dmem_req.we) begin  // Strobes seen in reset are ignored
            for (int i = 0; i < 4; i++) begin
                if (dmem_req.be[i]) begin
                    dmem[dmem_req.addr[7:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        r_type = {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        i_type = {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        b_type = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[n_words] = word;
        n_words++;
    endtask

    task automatic load_program();
        for (int i = 0; i < 128; i++) imem[i] = 32'h0000_0013;  // Fill with nop
        for (int i = 0; i < 64; i++) dmem[i] = 32'hC0DE_0000 | 32'(i);  // Word carries its index
        n_words = 0;
        emit(i_type(12'hFFB, X0, 3'b000, 5'd1, OPC_OP_IMM));   // addi x1, x0, -5
        emit(i_type(12'h003, X0, 3'b000, 5'd2, OPC_OP_IMM));   // addi x2, x0, 3
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));         // add  x3, x1, x2
        emit(s_type(12'h080, 5'd3, X0, 3'b010));               // sw   x3, 0x80(x0)
        emit(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));         // sub  x4, x2, x1
        emit(s_type(12'h084, 5'd4, X0, 3'b010));               // sw   x4, 0x84(x0)
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));         // and  x5, x1, x2
        emit(s_type(12'h088, 5'd5, X0, 3'b010));               // sw   x5, 0x88(x0)
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));         // or   x6, x1, x2
        emit(s_type(12'h08C, 5'd6, X0, 3'b010));               // sw   x6, 0x8c(x0)
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));         // xor  x7, x1, x2
        emit(s_type(12'h090, 5'd7, X0, 3'b010));               // sw   x7, 0x90(x0)
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));         // slt  x8, x1, x2
        emit(s_type(12'h094, 5'd8, X0, 3'b010));               // sw   x8, 0x94(x0)
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd9));         // sltu x9, x1, x2
        emit(s_type(12'h098, 5'd9, X0, 3'b010));               // sw   x9, 0x98(x0)
        emit(r_type(7'h00, 5'd2, 5'd2, 3'b001, 5'd10));        // sll  x10, x2, x2
        emit(s_type(12'h09C, 5'd10, X0, 3'b010));              // sw   x10, 0x9c(x0)
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd11));        // srl  x11, x1, x2
        emit(s_type(12'h0A0, 5'd11, X0, 3'b010));              // sw   x11, 0xa0(x0)
        emit(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd12));        // sra  x12, x1, x2
        emit(s_type(12'h0A4, 5'd12, X0, 3'b010));              // sw   x12, 0xa4(x0)
        emit(i_type(12'h0F0, 5'd1, 3'b100, 5'd13, OPC_OP_IMM)); // xori x13, x1, 0xf0
        emit(s_type(12'h0A8, 5'd13, X0, 3'b010));              // sw   x13, 0xa8(x0)
        emit(i_type(12'hFFC, 5'd1, 3'b010, 5'd14, OPC_OP_IMM)); // slti x14, x1, -4
        emit(i_type(12'hFFF, 5'd2, 3'b011, 5'd15, OPC_OP_IMM)); // sltiu x15, x2, -1
        emit(r_type(7'h00, 5'd15, 5'd14, 3'b000, 5'd16));      // add  x16, x14, x15
        emit(s_type(12'h0AC, 5'd16, X0, 3'b010));              // sw   x16, 0xac(x0)
        emit(i_type(12'h401, 5'd1, 3'b101, 5'd17, OPC_OP_IMM)); // srai x17, x1, 1
        emit(s_type(12'h0B0, 5'd17, X0, 3'b010));              // sw   x17, 0xb0(x0)
        emit(i_type(12'h07C, 5'd1, 3'b111, 5'd18, OPC_OP_IMM)); // andi x18, x1, 0x7c
        emit(s_type(12'h0B4, 5'd18, X0, 3'b010));              // sw   x18, 0xb4(x0)
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, X0));           // add  x0, x1, x2
        emit(s_type(12'h0B8, X0, X0, 3'b010));                 // sw   x0, 0xb8(x0)
        emit({20'h12345, 5'd21, OPC_LUI});                     // lui  x21, 0x12345
        emit(s_type(12'h0BC, 5'd21, X0, 3'b010));              // sw   x21, 0xbc(x0)
        emit({20'h00001, 5'd22, OPC_AUIPC});                   // auipc x22, 0x1 at 0x90
        emit(s_type(12'h0C0, 5'd22, X0, 3'b010));              // sw   x22, 0xc0(x0)
        emit(j_type(21'd8, 5'd23));                            // jal  x23, +8 at 0x98
        emit(s_type(12'h0F0, X0, X0, 3'b010));                 // sw   x0, 0xf0(x0) skipped
        emit(s_type(12'h0C4, 5'd23, X0, 3'b010));              // sw   x23, 0xc4(x0)
        emit(i_type(12'h0B0, X0, 3'b000, 5'd25, OPC_JALR));    // jalr x25, 0xb0(x0) at 0xa4
        emit(s_type(12'h0F0, X0, X0, 3'b010));                 // sw   x0, 0xf0(x0) skipped
        emit(s_type(12'h0F0, X0, X0, 3'b010));                 // sw   x0, 0xf0(x0) skipped
        emit(s_type(12'h0C8, 5'd25, X0, 3'b010));              // sw   x25, 0xc8(x0)
        emit(b_type(13'd8, 5'd2, 5'd2, 3'b000));               // beq  x2, x2, +8 taken
        emit(s_type(12'h0F0, X0, X0, 3'b010));                 // sw   x0, 0xf0(x0) skipped
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b000));               // beq  x1, x2, +8 not taken
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));               // bne  x1, x2, +8 taken
        emit(s_type(12'h0F0, X0, X0, 3'b010));                 // sw   x0, 0xf0(x0) skipped
        emit(b_type(13'd8, 5'd2, 5'd2, 3'b001));               // bne  x2, x2, +8 not taken
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b100));               // blt  x1, x2, +8 taken
        emit(s_type(12'h0F0, X0, X0, 3'b010));                 // sw   x0, 0xf0(x0) skipped
        emit(b_type(13'd8, 5'd1, 5'd2, 3'b100));               // blt  x2, x1, +8 not taken
        emit(b_type(13'd8, 5'd1, 5'd2, 3'b101));               // bge  x2, x1, +8 taken
        emit(s_type(12'h0F0, X0, X0, 3'b010));                 // sw   x0, 0xf0(x0) skipped
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b101));               // bge  x1, x2, +8 not taken
        emit(b_type(13'd8, 5'd1, 5'd2, 3'b110));               // bltu x2, x1, +8 taken
        emit(s_type(12'h0F0, X0, X0, 3'b010));                 // sw   x0, 0xf0(x0) skipped
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b110));               // bltu x1, x2, +8 not taken
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b111));               // bgeu x1, x2, +8 taken
        emit(s_type(12'h0F0, X0, X0, 3'b010));                 // sw   x0, 0xf0(x0) skipped
        emit(b_type(13'd8, 5'd1, 5'd2, 3'b111));               // bgeu x2, x1, +8 not taken
        emit(s_type(12'h0CC, 5'd2, X0, 3'b010));               // sw   x2, 0xcc(x0)
        emit(s_type(12'h0E0, 5'd1, X0, 3'b000));               // sb   x1, 0xe0(x0)
        emit(s_type(12'h0E1, 5'd1, X0, 3'b000));               // sb   x1, 0xe1(x0)
        emit(s_type(12'h0E2, 5'd1, X0, 3'b000));               // sb   x1, 0xe2(x0)
        emit(s_type(12'h0E3, 5'd1, X0, 3'b000));               // sb   x1, 0xe3(x0)
        emit(s_type(12'h0E4, 5'd13, X0, 3'b001));              // sh   x13, 0xe4(x0)
        emit(s_type(12'h0E6, 5'd13, X0, 3'b001));              // sh   x13, 0xe6(x0)
        emit(i_type(12'h0E5, X0, 3'b000, 5'd26, OPC_LOAD));    // lb   x26, 0xe5(x0)
        emit(s_type(12'h0D0, 5'd26, X0, 3'b010));              // sw   x26, 0xd0(x0)
        emit(i_type(12'h0E7, X0, 3'b100, 5'd27, OPC_LOAD));    // lbu  x27, 0xe7(x0)
        emit(s_type(12'h0D4, 5'd27, X0, 3'b010));              // sw   x27, 0xd4(x0)
        emit(i_type(12'h0E6, X0, 3'b001, 5'd28, OPC_LOAD));    // lh   x28, 0xe6(x0)
        emit(s_type(12'h0D8, 5'd28, X0, 3'b010));              // sw   x28, 0xd8(x0)
        emit(i_type(12'h0E4, X0, 3'b101, 5'd29, OPC_LOAD));    // lhu  x29, 0xe4(x0)
        emit(s_type(12'h0DC, 5'd29, X0, 3'b010));              // sw   x29, 0xdc(x0)
        emit(i_type(12'h0E4, X0, 3'b010, 5'd30, OPC_LOAD));    // lw   x30, 0xe4(x0)
        emit(s_type(12'h0E8, 5'd30, X0, 3'b010));              // sw   x30, 0xe8(x0)
        emit(i_type(12'hFF0, 5'd2, 3'b110, 5'd19, OPC_OP_IMM)); // ori  x19, x2, -16
        emit(s_type(12'h0EC, 5'd19, X0, 3'b010));              // sw   x19, 0xec(x0)
        emit(i_type(12'h004, 5'd1, 3'b001, 5'd20, OPC_OP_IMM)); // slli x20, x1, 4
        emit(s_type(12'h0F4, 5'd20, X0, 3'b010));              // sw   x20, 0xf4(x0)
        emit(i_type(12'h01C, 5'd1, 3'b101, 5'd24, OPC_OP_IMM)); // srli x24, x1, 28
        emit(s_type(12'h0F8, 5'd24, X0, 3'b010));              // sw   x24, 0xf8(x0)
        emit(j_type(21'd0, X0));                               // jal  x0, 0 at 0x158
    endtask

    task automatic add_entry(input string name, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             input logic [31:0] word);
        names[n_entries]    = name;
        exp_req[n_entries]  = '{addr: addr, wdata: wdata, be: be, we: 1'b1};
        exp_word[n_entries] = word;
        n_entries++;
    endtask

    task automatic fill_table();
        n_entries = 0;
        add_entry("add",    32'h80, 32'hFFFF_FFFE, 4'hF, 32'hFFFF_FFFE);  // -5 + 3
        add_entry("sub",    32'h84, 32'h0000_0008, 4'hF, 32'h0000_0008);
        add_entry("and",    32'h88, 32'h0000_0003, 4'hF, 32'h0000_0003);
        add_entry("or",     32'h8C, 32'hFFFF_FFFB, 4'hF, 32'hFFFF_FFFB);
        add_entry("xor",    32'h90, 32'hFFFF_FFF8, 4'hF, 32'hFFFF_FFF8);
        add_entry("slt",    32'h94, 32'h0000_0001, 4'hF, 32'h0000_0001);  // Signed -5 < 3
        add_entry("sltu",   32'h98, 32'h0000_0000, 4'hF, 32'h0000_0000);
        add_entry("sll",    32'h9C, 32'h0000_0018, 4'hF, 32'h0000_0018);
        add_entry("srl",    32'hA0, 32'h1FFF_FFFF, 4'hF, 32'h1FFF_FFFF);
        add_entry("sra",    32'hA4, 32'hFFFF_FFFF, 4'hF, 32'hFFFF_FFFF);
        add_entry("xori",   32'hA8, 32'hFFFF_FF0B, 4'hF, 32'hFFFF_FF0B);
        add_entry("slti",   32'hAC, 32'h0000_0002, 4'hF, 32'h0000_0002);  // Both compares true
        add_entry("srai",   32'hB0, 32'hFFFF_FFFD, 4'hF, 32'hFFFF_FFFD);
        add_entry("andi",   32'hB4, 32'h0000_0078, 4'hF, 32'h0000_0078);
        add_entry("x0",     32'hB8, 32'h0000_0000, 4'hF, 32'h0000_0000);
        add_entry("lui",    32'hBC, 32'h1234_5000, 4'hF, 32'h1234_5000);
        add_entry("auipc",  32'hC0, 32'h0000_1090, 4'hF, 32'h0000_1090);
        add_entry("jal",    32'hC4, 32'h0000_009C, 4'hF, 32'h0000_009C);  // Link is PC+4
        add_entry("jalr",   32'hC8, 32'h0000_00A8, 4'hF, 32'h0000_00A8);
        add_entry("branch", 32'hCC, 32'h0000_0003, 4'hF, 32'h0000_0003);
        add_entry("sb0",    32'hE0, 32'hFBFB_FBFB, 4'h1, 32'hC0DE_00FB);  // Byte replicated
        add_entry("sb1",    32'hE1, 32'hFBFB_FBFB, 4'h2, 32'hC0DE_FBFB);
        add_entry("sb2",    32'hE2, 32'hFBFB_FBFB, 4'h4, 32'hC0FB_FBFB);
        add_entry("sb3",    32'hE3, 32'hFBFB_FBFB, 4'h8, 32'hFBFB_FBFB);
        add_entry("sh0",    32'hE4, 32'hFF0B_FF0B, 4'h3, 32'hC0DE_FF0B);
        add_entry("sh2",    32'hE6, 32'hFF0B_FF0B, 4'hC, 32'hFF0B_FF0B);
        add_entry("lb",     32'hD0, 32'hFFFF_FFFF, 4'hF, 32'hFFFF_FFFF);
        add_entry("lbu",    32'hD4, 32'h0000_00FF, 4'hF, 32'h0000_00FF);
        add_entry("lh",     32'hD8, 32'hFFFF_FF0B, 4'hF, 32'hFFFF_FF0B);
        add_entry("lhu",    32'hDC, 32'h0000_FF0B, 4'hF, 32'h0000_FF0B);
        add_entry("lw",     32'hE8, 32'hFF0B_FF0B, 4'hF, 32'hFF0B_FF0B);
        add_entry("ori",    32'hEC, 32'hFFFF_FFF3, 4'hF, 32'hFFFF_FFF3);  // 3 | -16
        add_entry("slli",   32'hF4, 32'hFFFF_FFB0, 4'hF, 32'hFFFF_FFB0);
        add_entry("srli",   32'hF8, 32'h0000_000F, 4'hF, 32'h0000_000F);  // Zero fill from the top
    endtask

    task automatic check_req(input string name, input dmem_req_t expected,
                             input dmem_req_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s memory word: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s pc: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out: %s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    initial begin
        int cycles;
        int stable;
        logic [31:0] prev_pc;
        load_program();
        fill_table();
        cycles = 0;
        while (!rst_n) begin  // Reset release, bounded
            @(negedge clk);
            cycles++;
            if (cycles > 50) report_timeout("reset never released");
        end
        for (int e = 0; e < n_entries; e++) begin
            cycles = 0;
            while (!dmem_req.we) begin  // Outputs are settled at the falling edge
                @(negedge clk);
                cycles++;
                if (cycles > 200) report_timeout({"no store seen for ", names[e]});
            end
            check_req(names[e], exp_req[e], dmem_req);
            @(negedge clk);  // Store committed at the rising edge in between
            check_word(names[e], exp_word[e], dmem[exp_req[e].addr[7:2]]);
        end
        cycles  = 0;
        stable  = 0;
        prev_pc = pc;
        while (stable < 2) begin  // Wait until pc stops moving
            @(negedge clk);
            stable  = (pc == prev_pc) ? stable + 1 : 0;
            prev_pc = pc;
            cycles++;
            if (cycles > 50) report_timeout("pc never settled");
        end
        check_pc("halt", HALT_PC, pc);
        $display("TEST PASSED");
        $finish;
    end
endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;  // Reset is held from time zero
    end

    always #2 clk = ~clk;  // 4 ns period

    initial begin
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;  // Released on a rising edge like the other stimulus
    end
endmodule

`default_nettype wire

//--- logic/riscv_core.sv
`default_nettype none

module riscv_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [31:0]          instr,       // Word fetched at pc
    input  logic [31:0]          dmem_rdata,  // Word at the aligned request address
    output logic [31:0]          pc,
    output riscv_pkg::dmem_req_t dmem_req
);
    import riscv_pkg::*;

    ctrl_t       ctrl;
    alu_flags_t  alu_flags;
    logic [31:0] alu_out;     // Also the data address
    logic [31:0] write_data;
    logic [31:0] load_data;

    control_unit control_unit_inst (
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl)
    );

    datapath datapath_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (load_data),
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_out    (alu_out),
        .alu_flags  (alu_flags),
        .write_data (write_data)
    );

    load_store_unit load_store_unit_inst (
        .ctrl       (ctrl),
        .addr       (alu_out),
        .write_data (write_data),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .load_data  (load_data)
    );
endmodule

`default_nettype wire

//--- logic/load_store_unit.sv
`default_nettype none

module load_store_unit (
    input  riscv_pkg::ctrl_t     ctrl,
    input  logic [31:0]          addr,
    input  logic [31:0]          write_data,
    input  logic [31:0]          dmem_rdata,
    output riscv_pkg::dmem_req_t dmem_req,
    output logic [31:0]          load_data
);
    import riscv_pkg::*;

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    always_comb begin
        dmem_req.addr = addr;  // Memory uses the word index of this address
        dmem_req.we   = ctrl.mem_we;
        case (ctrl.store_size)
            MEM_BYTE: begin
                dmem_req.wdata = {4{write_data[7:0]}};  // Byte lands in every lane
                dmem_req.be    = 4'b0001 << addr[1:0];
            end
            MEM_HALF: begin
                dmem_req.wdata = {2{write_data[15:0]}};
                dmem_req.be    = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dmem_req.wdata = write_data;
                dmem_req.be    = 4'b1111;  // Full word
            end
        endcase
    end

    assign load_byte = 8'(dmem_rdata >> {addr[1:0], 3'b000});  // Lane picked by offset
    assign load_half = addr[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

    always_comb begin
        case (ctrl.result_src)
            RES_SRC_MEM_BYTE:  load_data = {{24{load_byte[7]}}, load_byte};
            RES_SRC_MEM_HALF:  load_data = {{16{load_half[15]}}, load_half};
            RES_SRC_MEM_UBYTE: load_data = {24'd0, load_byte};
            RES_SRC_MEM_UHALF: load_data = {16'd0, load_half};
            default:           load_data = dmem_rdata;  // lw and non-loads
        endcase
    end
endmodule

`default_nettype wire

//--- logic/control_unit.sv
`default_nettype none

module control_unit (
    input  logic [31:0]           instr,
    input  riscv_pkg::alu_flags_t alu_flags,
    output riscv_pkg::ctrl_t      ctrl
);
    import riscv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_alt;
    logic       branch_taken;

    function automatic alu_op_e decode_alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  decode_alu_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  decode_alu_op = ALU_SLL;
            3'b010:  decode_alu_op = ALU_SLT;
            3'b011:  decode_alu_op = ALU_SLTU;
            3'b100:  decode_alu_op = ALU_XOR;
            3'b101:  decode_alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  decode_alu_op = ALU_OR;
            default: decode_alu_op = ALU_AND;
        endcase
    endfunction

    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];  // Selects sub and sra

    always_comb begin
        case (funct3)
            3'b000:  branch_taken = alu_flags.zero;                           // beq
            3'b001:  branch_taken = ~alu_flags.zero;                          // bne
            3'b100:  branch_taken = alu_flags.negative ^ alu_flags.overflow;  // blt
            3'b101:  branch_taken = ~(alu_flags.negative ^ alu_flags.overflow);
            3'b110:  branch_taken = ~alu_flags.carry;                         // bltu
            3'b111:  branch_taken = alu_flags.carry;                          // bgeu
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl.reg_we     = 1'b0;  // Defaults form a no-op
        ctrl.imm_src    = IMM_SRC_ITYPE;
        ctrl.alu_ctrl   = ALU_ADD;
        ctrl.alu_src    = ALU_SRC_EXT_IMM;
        ctrl.result_src = RES_SRC_ALU_OUT;
        ctrl.pc_src     = PC_SRC_PLUS_4;
        ctrl.mem_we     = 1'b0;
        ctrl.store_size = MEM_WORD;

        case (opcode)
            OPC_OP: begin
                ctrl.reg_we   = 1'b1;
                ctrl.alu_src  = ALU_SRC_REG;
                ctrl.alu_ctrl = decode_alu_op(funct3, funct7_alt);
            end
            OPC_OP_IMM: begin
                ctrl.reg_we   = 1'b1;
                ctrl.alu_ctrl = decode_alu_op(funct3, (funct3 == 3'b101) && funct7_alt);
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    ctrl.imm_src = IMM_SRC_ITYPE2;  // Shifts take only shamt
                end
            end
            OPC_LOAD: begin
                ctrl.reg_we = 1'b1;
                case (funct3)
                    3'b000:  ctrl.result_src = RES_SRC_MEM_BYTE;
                    3'b001:  ctrl.result_src = RES_SRC_MEM_HALF;
                    3'b100:  ctrl.result_src = RES_SRC_MEM_UBYTE;
                    3'b101:  ctrl.result_src = RES_SRC_MEM_UHALF;
                    default: ctrl.result_src = RES_SRC_MEM_WORD;
                endcase
            end
            OPC_STORE: begin
                ctrl.imm_src    = IMM_SRC_STYPE;
                ctrl.mem_we     = 1'b1;
                ctrl.store_size = mem_size_e'(funct3[1:0]);
            end
            OPC_BRANCH: begin
                ctrl.imm_src  = IMM_SRC_BTYPE;
                ctrl.alu_src  = ALU_SRC_REG;
                ctrl.alu_ctrl = ALU_SUB;  // Flags of rs1 - rs2 decide
                ctrl.pc_src   = branch_taken ? PC_SRC_PLUS_OFF : PC_SRC_PLUS_4;
            end
            OPC_JAL: begin
                ctrl.reg_we     = 1'b1;
                ctrl.imm_src    = IMM_SRC_JTYPE;
                ctrl.result_src = RES_SRC_PC_PLUS_4;
                ctrl.pc_src     = PC_SRC_PLUS_OFF;
            end
            OPC_JALR: begin
                ctrl.reg_we     = 1'b1;
                ctrl.result_src = RES_SRC_PC_PLUS_4;
                ctrl.pc_src     = PC_SRC_REG_PLUS_OFF;
            end
            OPC_LUI: begin
                ctrl.reg_we     = 1'b1;
                ctrl.imm_src    = IMM_SRC_UTYPE;
                ctrl.result_src = RES_SRC_EXT_IMM;  // Bypasses the ALU
            end
            OPC_AUIPC: begin
                ctrl.reg_we  = 1'b1;
                ctrl.imm_src = IMM_SRC_UTYPE;
                ctrl.alu_src = ALU_SRC_PC_EXT_IMM;
            end
            default: ;  // Unknown opcodes fall through as a no-op
        endcase
    end
endmodule

`default_nettype wire

//--- logic/datapath.sv
`default_nettype none

module extend (
    input  logic [31:0]         instr,
    input  riscv_pkg::imm_src_e imm_src,
    output logic [31:0]         ext_imm
);
    import riscv_pkg::*;

    always_comb begin
        case (imm_src)
            IMM_SRC_ITYPE:  ext_imm = {{20{instr[31]}}, instr[31:20]};
            IMM_SRC_STYPE:  ext_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_SRC_BTYPE:  ext_imm = {{19{instr[31]}}, instr[31], instr[7],
                                       instr[30:25], instr[11:8], 1'b0};  // Even offset
            IMM_SRC_JTYPE:  ext_imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                       instr[20], instr[30:21], 1'b0};
            IMM_SRC_UTYPE:  ext_imm = {instr[31:12], 12'h000};  // Upper 20 bits in place
            IMM_SRC_ITYPE2: ext_imm = {27'd0, instr[24:20]};     // Shift amount is unsigned
            default:        ext_imm = 32'h0;                    // Unused code gives zero
        endcase
    end
endmodule

module regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  addr1,
    input  logic [4:0]  addr2,
    input  logic [4:0]  addr3,
    input  logic [31:0] wd3,
    input  logic        we,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [32];  // Entry 0 exists but is never read

    always_ff @(posedge clk) begin
        if (rst_n && we && (addr3 != 5'd0)) begin  // Writes to x0 are dropped
            regs[addr3] <= wd3;
        end
    end

    assign rd1 = (addr1 == 5'd0) ? 32'h0 : regs[addr1];  // x0 always reads zero
    assign rd2 = (addr2 == 5'd0) ? 32'h0 : regs[addr2];
endmodule

module datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           instr,
    input  logic [31:0]           read_data,
    input  riscv_pkg::ctrl_t      ctrl,
    output logic [31:0]           pc,
    output logic [31:0]           alu_out,
    output riscv_pkg::alu_flags_t alu_flags,
    output logic [31:0]           write_data
);
    import riscv_pkg::*;

    logic [31:0] ext_imm;
    logic [31:0] reg_rd1;
    logic [31:0] reg_rd2;
    logic [31:0] reg_wr_data;
    logic [31:0] pc_plus_4;
    logic [31:0] pc_plus_off;
    logic [31:0] pc_reg_plus_off;
    logic [31:0] pc_next;
    logic [31:0] alu_srca;
    logic [31:0] alu_srcb;

    extend extend_inst (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .ext_imm (ext_imm)
    );

    regfile regfile_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .addr1 (instr[19:15]),  // rs1
        .addr2 (instr[24:20]),  // rs2
        .addr3 (instr[11:7]),   // rd
        .wd3   (reg_wr_data),
        .we    (ctrl.reg_we),
        .rd1   (reg_rd1),
        .rd2   (reg_rd2)
    );

    alu alu_inst (
        .srca     (alu_srca),
        .srcb     (alu_srcb),
        .alu_ctrl (ctrl.alu_ctrl),
        .result   (alu_out),
        .flags    (alu_flags)
    );

    assign pc_plus_4       = pc + 32'd4;
    assign pc_plus_off     = pc + ext_imm;                      // Branch and jal target
    assign pc_reg_plus_off = (reg_rd1 + ext_imm) & ~32'd1;      // jalr clears bit 0

    always_comb begin
        case (ctrl.pc_src)
            PC_SRC_PLUS_OFF:     pc_next = pc_plus_off;
            PC_SRC_REG_PLUS_OFF: pc_next = pc_reg_plus_off;
            default:             pc_next = pc_plus_4;  // Sequential fetch
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;  // One instruction retires per edge
        end
    end

    always_comb begin
        case (ctrl.alu_src)
            ALU_SRC_REG:        {alu_srca, alu_srcb} = {reg_rd1, reg_rd2};
            ALU_SRC_PC_EXT_IMM: {alu_srca, alu_srcb} = {pc, ext_imm};  // auipc
            default:            {alu_srca, alu_srcb} = {reg_rd1, ext_imm};
        endcase
    end

    always_comb begin
        case (ctrl.result_src)
            RES_SRC_MEM_BYTE, RES_SRC_MEM_HALF, RES_SRC_MEM_WORD,
            RES_SRC_MEM_UBYTE, RES_SRC_MEM_UHALF:
                reg_wr_data = read_data;  // Already aligned and extended by the LSU
            RES_SRC_PC_PLUS_4: reg_wr_data = pc_plus_4;
            RES_SRC_EXT_IMM:   reg_wr_data = ext_imm;
            default:           reg_wr_data = alu_out;
        endcase
    end

    assign write_data = reg_rd2;  // Store data is always rs2
endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
    input  logic [31:0]           srca,
    input  logic [31:0]           srcb,
    input  riscv_pkg::alu_op_e    alu_ctrl,
    output logic [31:0]           result,
    output riscv_pkg::alu_flags_t flags
);
    import riscv_pkg::*;

    logic        sub;
    logic [31:0] srcb_eff;
    logic [32:0] sum;
    logic [4:0]  shamt;

    assign sub      = (alu_ctrl == ALU_SUB) || (alu_ctrl == ALU_SLT) || (alu_ctrl == ALU_SLTU);
    assign srcb_eff = sub ? ~srcb : srcb;                           // Two's complement with carry-in
    assign sum      = {1'b0, srca} + {1'b0, srcb_eff} + {32'd0, sub};
    assign shamt    = srcb[4:0];                                   // Only five bits shift

    always_comb begin
        flags.negative = sum[31];
        flags.zero     = (sum[31:0] == 32'd0);
        flags.carry    = sum[32];  // On subtract this means srca >= srcb unsigned
        flags.overflow = (srca[31] == srcb_eff[31]) && (sum[31] != srca[31]);
    end

    always_comb begin
        case (alu_ctrl)
            ALU_AND:  result = srca & srcb;
            ALU_OR:   result = srca | srcb;
            ALU_XOR:  result = srca ^ srcb;
            ALU_SLL:  result = srca << shamt;
            ALU_SRL:  result = srca >> shamt;
            ALU_SRA:  result = $unsigned($signed(srca) >>> shamt);  // Keeps the sign bit
            ALU_SLT:  result = {31'd0, flags.negative ^ flags.overflow};
            ALU_SLTU: result = {31'd0, ~flags.carry};                // Borrow means less
            default:  result = sum[31:0];                           // ADD and SUB
        endcase
    end
endmodule

`default_nettype wire

//--- logic/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;  // Address of the first fetch

    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register arithmetic
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate arithmetic
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // Conditional branches
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [2:0] {
        IMM_SRC_ITYPE,
        IMM_SRC_STYPE,
        IMM_SRC_BTYPE,
        IMM_SRC_JTYPE,
        IMM_SRC_UTYPE,
        IMM_SRC_ITYPE2     // Unsigned 5-bit shift amount
    } imm_src_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_SRC_EXT_IMM,       // Operands are rs1 and the immediate
        ALU_SRC_REG,           // Operands are rs1 and rs2
        ALU_SRC_PC_EXT_IMM     // Operands are the PC and the immediate
    } alu_src_e;

    typedef enum logic [2:0] {
        RES_SRC_ALU_OUT,
        RES_SRC_MEM_BYTE,
        RES_SRC_MEM_HALF,
        RES_SRC_MEM_WORD,
        RES_SRC_MEM_UBYTE,
        RES_SRC_MEM_UHALF,
        RES_SRC_PC_PLUS_4,     // Link value of jal and jalr
        RES_SRC_EXT_IMM        // Used by lui
    } res_src_e;

    typedef enum logic [1:0] {
        PC_SRC_PLUS_4,
        PC_SRC_PLUS_OFF,       // Taken branch or jal
        PC_SRC_REG_PLUS_OFF    // Target of jalr
    } pc_src_e;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;              // Encoding matches funct3[1:0] of the store opcodes

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;           // Set when there is no borrow on subtract
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        logic      reg_we;
        imm_src_e  imm_src;
        alu_op_e   alu_ctrl;
        alu_src_e  alu_src;
        res_src_e  result_src;
        pc_src_e   pc_src;
        logic      mem_we;
        mem_size_e store_size;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;       // One enable per byte lane
        logic        we;
    } dmem_req_t;

endpackage

`default_nettype wire
